/* verilog/keypad_pkg.sv */
// ====================
// Keypad package
// Shared widths, bundles, FSM states and timing constants
// for the keypad scanner and two-digit display
// ====================

package keypad_pkg;

    // ====================
    // Timing constants
    // ====================
    localparam int SCAN_DIV        = 4;   // Clocks per row step
    localparam int DEBOUNCE_CYCLES = 16;  // Clocks a condition must hold
    localparam int MUX_DIV         = 8;   // Clocks per displayed digit
    localparam int CNT_W           = 5;   // Debounce / mux counter width

    // ====================
    // Vector types
    // ====================
    typedef logic [3:0]       row_t;       // Active-low row drive
    typedef logic [3:0]       col_t;       // Active-low column inputs
    typedef logic [3:0]       key_code_t;  // Hex key value
    typedef logic [6:0]       seg_t;       // Active-low segments, bit 0 = a
    typedef logic [CNT_W-1:0] cnt_t;       // Shared counter type

    // Terminal counts, sized to the counters
    localparam cnt_t SCAN_LAST = cnt_t'(SCAN_DIV - 1);
    localparam cnt_t DEB_LAST  = cnt_t'(DEBOUNCE_CYCLES - 1);
    localparam cnt_t MUX_LAST  = cnt_t'(MUX_DIV - 1);

    // ====================
    // Bundles
    // ====================
    typedef struct packed {
        row_t row;       // Row currently driven low
        col_t col;       // Synchronized columns
        logic detected;  // Some column is low
    } scan_t;

    typedef struct packed {
        logic      valid;  // One-cycle strobe
        key_code_t code;   // Accepted key
    } key_event_t;

    typedef struct packed {
        key_code_t left;
        key_code_t right;
    } digits_t;

    // Debounce FSM
    typedef enum logic [1:0] {
        DEB_IDLE    = 2'd0,  // Scanning, no key
        DEB_PRESS   = 2'd1,  // Candidate key, checking stability
        DEB_HELD    = 2'd2,  // Key accepted, waiting for release
        DEB_RELEASE = 2'd3   // Release seen, checking stability
    } deb_state_e;

endpackage

/* verilog/keypad_scanner.sv */
// ====================
// Keypad scanner
// Walks a single low bit across the rows and
// synchronizes the column inputs
// ====================

`timescale 1ns/100ps

module keypad_scanner (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              scan_stop,  // Hold current row
    input  keypad_pkg::col_t  cols,       // Raw column pins
    output keypad_pkg::row_t  rows,       // Row drive, one bit low
    output keypad_pkg::scan_t scan
);

    keypad_pkg::cnt_t step_cnt;  // Clocks spent on this row
    keypad_pkg::col_t col_meta;  // First sync stage
    keypad_pkg::col_t col_sync;  // Second sync stage
    logic             step_end;

    assign step_end = (step_cnt == keypad_pkg::SCAN_LAST);

    // ====================
    // Row rotation
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
            rows     <= 4'b1110;  // Start on row 0
        end else if (!scan_stop) begin
            if (step_end) begin
                step_cnt <= '0;
                rows     <= {rows[2:0], rows[3]};  // Low bit moves up one row
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
        // Frozen while a key is being handled
    end

    // ====================
    // Column synchronizer
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_meta <= '1;  // Idle columns are pulled high
            col_sync <= '1;
        end else begin
            col_meta <= cols;
            col_sync <= col_meta;
        end
    end

    // Bundle for decoder and debouncer
    always_comb begin
        scan.row      = rows;
        scan.col      = col_sync;
        scan.detected = ~&col_sync;  // Any column pulled low
    end

endmodule

/* verilog/keypad_decoder.sv */
// ====================
// Keypad decoder
// Maps driven row and low column to a hex key code
// ====================

`timescale 1ns/100ps

module keypad_decoder (
    input  keypad_pkg::scan_t     scan,
    output keypad_pkg::key_code_t raw_code,
    output logic                  single_key  // Exactly one column low
);

    logic [1:0] row_idx;
    logic [1:0] col_idx;

    // Active-low row drive to index
    always_comb begin
        case (scan.row)
            4'b1110: row_idx = 2'd0;
            4'b1101: row_idx = 2'd1;
            4'b1011: row_idx = 2'd2;
            4'b0111: row_idx = 2'd3;
            default: row_idx = 2'd0;  // Not reached, scanner keeps one low bit
        endcase
    end

    // Active-low column to index, zero or several low is not single
    always_comb begin
        single_key = 1'b1;
        case (scan.col)
            4'b1110: col_idx = 2'd0;
            4'b1101: col_idx = 2'd1;
            4'b1011: col_idx = 2'd2;
            4'b0111: col_idx = 2'd3;
            default: begin
                col_idx    = 2'd0;
                single_key = 1'b0;
            end
        endcase
    end

    // Keypad map
    always_comb begin
        case ({row_idx, col_idx})
            4'b00_00: raw_code = 4'h1;
            4'b00_01: raw_code = 4'h2;
            4'b00_10: raw_code = 4'h3;
            4'b00_11: raw_code = 4'hA;
            4'b01_00: raw_code = 4'h4;
            4'b01_01: raw_code = 4'h5;
            4'b01_10: raw_code = 4'h6;
            4'b01_11: raw_code = 4'hB;
            4'b10_00: raw_code = 4'h7;
            4'b10_01: raw_code = 4'h8;
            4'b10_10: raw_code = 4'h9;
            4'b10_11: raw_code = 4'hC;
            4'b11_00: raw_code = 4'hE;
            4'b11_01: raw_code = 4'h0;
            4'b11_10: raw_code = 4'hF;
            default:  raw_code = 4'hD;  // Row 3, column 3
        endcase
    end

endmodule

/* verilog/keypad_debouncer.sv */
// ====================
// Keypad debouncer
// Qualifies a press, emits one event per press,
// holds the scan until a stable release
// ====================

`timescale 1ns/100ps

module keypad_debouncer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  keypad_pkg::scan_t      scan,
    input  keypad_pkg::key_code_t  raw_code,
    input  logic                   single_key,
    output logic                   scan_stop,  // Freeze row rotation
    output keypad_pkg::key_event_t key_evt
);

    keypad_pkg::deb_state_e state;
    keypad_pkg::deb_state_e state_nxt;
    keypad_pkg::cnt_t       stable_cnt;   // Clocks in current check
    keypad_pkg::key_code_t  cand_code;    // Code latched on entry to PRESS
    logic                   evt_valid;
    logic                   press_start;  // Clean single key seen
    logic                   press_same;   // Candidate still present
    logic                   stable_done;

    assign press_start = scan.detected & single_key;
    assign press_same  = press_start & (raw_code == cand_code);
    assign stable_done = (stable_cnt == keypad_pkg::DEB_LAST);

    // ====================
    // Next state
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            keypad_pkg::DEB_IDLE: begin
                if (press_start)
                    state_nxt = keypad_pkg::DEB_PRESS;
            end
            keypad_pkg::DEB_PRESS: begin
                if (!press_same)
                    state_nxt = keypad_pkg::DEB_IDLE;  // Bounce or code changed
                else if (stable_done)
                    state_nxt = keypad_pkg::DEB_HELD;  // Accept
            end
            keypad_pkg::DEB_HELD: begin
                if (!scan.detected)
                    state_nxt = keypad_pkg::DEB_RELEASE;
            end
            keypad_pkg::DEB_RELEASE: begin
                if (scan.detected)
                    state_nxt = keypad_pkg::DEB_HELD;  // Still bouncing
                else if (stable_done)
                    state_nxt = keypad_pkg::DEB_IDLE;
            end
            default: state_nxt = keypad_pkg::DEB_IDLE;
        endcase
    end

    // ====================
    // State, counter, strobe
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= keypad_pkg::DEB_IDLE;
            stable_cnt <= '0;
            evt_valid  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state_nxt != state)
                stable_cnt <= '0;  // Fresh count per state
            else if ((state == keypad_pkg::DEB_PRESS) ||
                     (state == keypad_pkg::DEB_RELEASE))
                stable_cnt <= stable_cnt + 1'b1;
            // One pulse on PRESS -> HELD only
            evt_valid <= (state == keypad_pkg::DEB_PRESS) &&
                         (state_nxt == keypad_pkg::DEB_HELD);
        end
    end

    // Candidate code taken as the FSM leaves IDLE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cand_code <= '0;
        else if ((state == keypad_pkg::DEB_IDLE) && press_start)
            cand_code <= raw_code;
    end

    // Stop as soon as a key shows up so the row stays on it
    assign scan_stop = (state != keypad_pkg::DEB_IDLE) | press_start;

    always_comb begin
        key_evt.valid = evt_valid;
        key_evt.code  = cand_code;  // Stable through HELD
    end

endmodule

/* verilog/digit_display.sv */
// ====================
// Two-digit display
// Shift register of accepted keys, hex to segment
// encoder and digit multiplexer
// ====================

`timescale 1ns/100ps

module digit_display (
    input  logic                   clk,
    input  logic                   rst_n,
    input  keypad_pkg::key_event_t key_evt,
    output keypad_pkg::seg_t       seg,      // Active low
    output logic                   select0,  // Left digit enable
    output logic                   select1   // Right digit enable
);

    keypad_pkg::digits_t   digits;
    keypad_pkg::cnt_t      mux_cnt;
    keypad_pkg::key_code_t shown;     // Digit for the next cycle
    logic                  sel_left;
    logic                  sel_nxt;
    logic                  mux_end;

    // Hex to active-low segments, g..a
    function automatic keypad_pkg::seg_t hex_to_seg(input keypad_pkg::key_code_t hex);
        case (hex)
            4'h0: hex_to_seg = 7'b1000000;
            4'h1: hex_to_seg = 7'b1111001;
            4'h2: hex_to_seg = 7'b0100100;
            4'h3: hex_to_seg = 7'b0110000;
            4'h4: hex_to_seg = 7'b0011001;
            4'h5: hex_to_seg = 7'b0010010;
            4'h6: hex_to_seg = 7'b0000010;
            4'h7: hex_to_seg = 7'b1111000;
            4'h8: hex_to_seg = 7'b0000000;
            4'h9: hex_to_seg = 7'b0010000;
            4'hA: hex_to_seg = 7'b0001000;
            4'hB: hex_to_seg = 7'b0000011;  // Lower case b
            4'hC: hex_to_seg = 7'b1000110;
            4'hD: hex_to_seg = 7'b0100001;  // Lower case d
            4'hE: hex_to_seg = 7'b0000110;
            default: hex_to_seg = 7'b0001110;  // F
        endcase
    endfunction

    // ====================
    // Digit shift register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digits <= '0;
        end else if (key_evt.valid) begin
            digits.left  <= digits.right;  // Old key moves left
            digits.right <= key_evt.code;  // New key enters right
        end
    end

    // ====================
    // Multiplexer
    // ====================
    assign mux_end = (mux_cnt == keypad_pkg::MUX_LAST);
    assign sel_nxt = mux_end ? ~sel_left : sel_left;
    assign shown   = sel_nxt ? digits.left : digits.right;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mux_cnt  <= '0;
            sel_left <= 1'b1;         // Left digit first
            seg      <= hex_to_seg(4'h0);
        end else begin
            mux_cnt  <= mux_end ? '0 : mux_cnt + 1'b1;
            sel_left <= sel_nxt;
            seg      <= hex_to_seg(shown);  // Same edge as select, always in step
        end
    end

    assign select0 = sel_left;
    assign select1 = ~sel_left;

endmodule

/* verilog/keypad_top.sv */
// ====================
// Keypad top level
// Scanner, decoder, debouncer and two-digit display
// ====================

`timescale 1ns/100ps

module keypad_top (
    input  logic             clk,
    input  logic             rst_n,
    input  keypad_pkg::col_t keypad_cols,  // From keypad, pulled high
    output keypad_pkg::row_t keypad_rows,  // To keypad, one row low
    output keypad_pkg::seg_t seg,
    output logic             select0,
    output logic             select1
);

    // ====================
    // Internal wires
    // ====================
    keypad_pkg::scan_t      scan;       // Scanner bundle
    keypad_pkg::key_code_t  raw_code;   // Undebounced code
    logic                   single_key;
    logic                   scan_stop;  // Debouncer holds the row
    keypad_pkg::key_event_t key_evt;    // Accepted key strobe

    keypad_scanner scanner_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_stop (scan_stop),
        .cols      (keypad_cols),
        .rows      (keypad_rows),
        .scan      (scan)
    );

    keypad_decoder decoder_i (
        .scan       (scan),
        .raw_code   (raw_code),
        .single_key (single_key)
    );

    keypad_debouncer debouncer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan       (scan),
        .raw_code   (raw_code),
        .single_key (single_key),
        .scan_stop  (scan_stop),
        .key_evt    (key_evt)
    );

    digit_display display_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .key_evt (key_evt),
        .seg     (seg),
        .select0 (select0),
        .select1 (select1)
    );

endmodule

/* tests/keypad_model.sv */
// ====================
// Behavioral 4x4 keypad
// Pulls a column low while the pressed key's row is driven low,
// with a second key for double presses
// ====================

`timescale 1ns/100ps

module keypad_model (
    input  keypad_pkg::row_t rows,      // Row drive from the DUT
    input  logic             press,     // First key held
    input  logic [1:0]       key_row,
    input  logic [1:0]       key_col,
    input  logic             press2,    // Second key held
    input  logic [1:0]       key2_row,
    input  logic [1:0]       key2_col,
    output keypad_pkg::col_t cols       // Column pins, pulled high
);

    // Switch matrix, a closed key shorts its row onto its column
    always_comb begin
        cols = '1;  // Pull-ups
        if (press && !rows[key_row])
            cols[key_col] = 1'b0;
        if (press2 && !rows[key2_row])
            cols[key2_col] = 1'b0;   // Both keys can land on one column pattern
    end

endmodule

/* tests/keypad_tb.sv */
// ====================
// Keypad testbench
// Table of key presses applied in a loop with the display
// checked against a digit model and hex segment table
// ====================

`timescale 1ns/100ps

module keypad_tb;

    typedef logic [8*12-1:0] name_t;  // Twelve character test name

    typedef struct packed {
        name_t                 name;
        logic [1:0]            mode;   // No key, one key, two keys
        logic [1:0]            row;
        logic [1:0]            col;
        logic [1:0]            col2;   // Second key in the same row
        int                    hold;   // Cycles the keys stay closed
        keypad_pkg::key_code_t left;   // Expected digits afterwards
        keypad_pkg::key_code_t right;
    } stim_t;

    localparam logic [1:0] KEY_NONE = 2'd0;
    localparam logic [1:0] KEY_ONE  = 2'd1;
    localparam logic [1:0] KEY_TWO  = 2'd2;
    localparam int LATENCY = 4 * keypad_pkg::SCAN_DIV + keypad_pkg::DEBOUNCE_CYCLES + 4;
    localparam int N_TESTS = 9;

    // ====================
    // Stimulus table
    // ====================
    localparam stim_t STIM [N_TESTS] = '{
        '{"single_5    ", KEY_ONE, 2'd1, 2'd1, 2'd0,  40, 4'h0, 4'h5},
        '{"seq_1       ", KEY_ONE, 2'd0, 2'd0, 2'd0,  40, 4'h5, 4'h1},
        '{"seq_a       ", KEY_ONE, 2'd0, 2'd3, 2'd0,  40, 4'h1, 4'hA},
        '{"seq_e       ", KEY_ONE, 2'd3, 2'd0, 2'd0,  40, 4'hA, 4'hE},
        '{"seq_0       ", KEY_ONE, 2'd3, 2'd1, 2'd0,  40, 4'hE, 4'h0},
        '{"seq_d       ", KEY_ONE, 2'd3, 2'd3, 2'd0,  40, 4'h0, 4'hD},
        '{"glitch_3    ", KEY_ONE, 2'd0, 2'd2, 2'd0,   3, 4'h0, 4'hD},  // Too short
        '{"hold_9      ", KEY_ONE, 2'd2, 2'd2, 2'd0, 200, 4'hD, 4'h9},  // Only one shift
        '{"double_4_5  ", KEY_TWO, 2'd1, 2'd0, 2'd1,  60, 4'hD, 4'h9}   // Ignored
    };

    // Keypad map indexed by {row, col}
    localparam keypad_pkg::key_code_t KEY_MAP [16] = '{
        4'h1, 4'h2, 4'h3, 4'hA, 4'h4, 4'h5, 4'h6, 4'hB,
        4'h7, 4'h8, 4'h9, 4'hC, 4'hE, 4'h0, 4'hF, 4'hD
    };

    // Standard active-low hex patterns as g..a
    localparam keypad_pkg::seg_t SEG_MAP [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    logic                  clk;
    logic                  rst_n;
    logic                  press;
    logic                  press2;
    logic [1:0]            key_row;
    logic [1:0]            key_col;
    logic [1:0]            key_col2;
    keypad_pkg::col_t      keypad_cols;
    keypad_pkg::row_t      keypad_rows;
    keypad_pkg::seg_t      seg;
    logic                  select0;
    logic                  select1;
    keypad_pkg::key_code_t exp_left;   // Digit model
    keypad_pkg::key_code_t exp_right;
    int                    cycle_cnt = 0;
    int                    timeout_limit = 0;

    keypad_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .keypad_cols (keypad_cols),
        .keypad_rows (keypad_rows),
        .seg         (seg),
        .select0     (select0),
        .select1     (select1)
    );

    keypad_model kp_i (
        .rows     (keypad_rows),
        .press    (press),
        .key_row  (key_row),
        .key_col  (key_col),
        .press2   (press2),
        .key2_row (key_row),   // Double press stays in one row
        .key2_col (key_col2),
        .cols     (keypad_cols)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // Holds, release gaps and select waits plus margin
    function automatic int run_limit();
        int total;
        total = 2 + 4 * keypad_pkg::MUX_DIV + 100;
        for (int i = 0; i < N_TESTS; i++)
            total = total + STIM[i].hold + LATENCY + 4 * keypad_pkg::MUX_DIV + 2;
        return total;
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic check_seg(input name_t name, input logic want_left,
                             input keypad_pkg::seg_t exp);
        int    waited;
        string side;
        logic  other_sel;  // Select of the digit not shown
        waited = 0;
        if (want_left)
            side = "left";
        else
            side = "right";
        @(negedge clk);
        while ((want_left ? select0 : select1) == 1'b0) begin
            if (waited > 2 * keypad_pkg::MUX_DIV) begin
                $display("%s: digit select never became active", name);
                $display("Test failed");
                $fatal(1);
            end
            waited++;
            @(negedge clk);
        end
        other_sel = want_left ? select1 : select0;
        if (other_sel !== 1'b0) begin
            $display("CHECK FAILED %s (%s digit other select): expected 0, actual %b",
                     name, side, other_sel);
            $display("Test failed");
            $fatal(1);
        end
        if (seg !== exp) begin
            $display("CHECK FAILED %s (%s digit): expected %b, actual %b",
                     name, side, exp, seg);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_rows(input name_t name, input keypad_pkg::row_t rows);
        int lows;
        lows = 0;
        for (int b = 0; b < 4; b++)
            if (!rows[b])
                lows++;
        if (lows != 1) begin
            $display("CHECK FAILED %s: expected one low row, actual %b", name, rows);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic drive_keys(input stim_t s);
        press    = (s.mode != KEY_NONE);
        press2   = (s.mode == KEY_TWO);
        key_row  = s.row;
        key_col  = s.col;
        key_col2 = s.col2;
    endtask

    task automatic release_keys();
        press  = 1'b0;
        press2 = 1'b0;
    endtask

    // Row drive watched every cycle
    always @(negedge clk) begin
        if (rst_n)
            check_rows("row_drive   ", keypad_rows);
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt > timeout_limit) begin
            $display("Timeout after %0d cycles, display never settled", cycle_cnt);
            $display("Test failed");
            $fatal(1);
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        timeout_limit = run_limit();
        rst_n     = 1'b0;
        press     = 1'b0;
        press2    = 1'b0;
        key_row   = 2'd0;
        key_col   = 2'd0;
        key_col2  = 2'd0;
        exp_left  = 4'h0;
        exp_right = 4'h0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        check_seg("reset       ", 1'b1, SEG_MAP[exp_left]);
        check_seg("reset       ", 1'b0, SEG_MAP[exp_right]);

        for (int i = 0; i < N_TESTS; i++) begin
            @(posedge clk);
            #1 drive_keys(STIM[i]);
            repeat (STIM[i].hold) @(posedge clk);
            #1 release_keys();
            repeat (LATENCY) @(posedge clk);  // Release debounce and worst press latency

            // Only a clean single key held past the latency shifts in
            if (STIM[i].mode == KEY_ONE && STIM[i].hold >= LATENCY) begin
                exp_left  = exp_right;
                exp_right = KEY_MAP[{STIM[i].row, STIM[i].col}];
            end
            if (exp_left !== STIM[i].left || exp_right !== STIM[i].right) begin
                $display("%s: stimulus table disagrees with digit model", STIM[i].name);
                $display("Test failed");
                $fatal(1);
            end

            check_seg(STIM[i].name, 1'b1, SEG_MAP[exp_left]);
            check_seg(STIM[i].name, 1'b0, SEG_MAP[exp_right]);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* all.f */
verilog/keypad_pkg.sv
verilog/keypad_scanner.sv
verilog/keypad_decoder.sv
verilog/keypad_debouncer.sv
verilog/digit_display.sv
verilog/keypad_top.sv
tests/keypad_model.sv
tests/keypad_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = keypad_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $$fatal in the testbench gives a nonzero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
